// File: Bender.yml
package:
  name: ppu_core

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ppu_pixel_pkg.sv
      - hdl/ppu_cfg_pkg.sv
      - hdl/ppu_ctrl_regs.sv
      - hdl/ppu_raster_counter.sv
      - hdl/ppu_blender.sv
      - hdl/ppu_palette_mapper.sv
      - hdl/ppu_core.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/tb_ppu_core.sv

// File: bench/tb_ppu_core.sv
`timescale 1ns/1ps
`include "ppu_defines.svh"

module tb_ppu_core;

	localparam int          N_TESTS = 25;
	localparam int          FRAME   = 8;
	localparam logic [14:0] DEF_BG  = 15'h2b4d;

	logic                      clk_ppu;
	logic                      rst_n_ppu;
	ppu_cfg_pkg::reg_wr_t      reg_wr_i;
	logic                      run_i;
	logic                      halt_i;
	logic [1:0]                layer_vld_i;
	logic [1:0]                layer_rdy_o;
	ppu_pixel_pkg::layer_pix_t layer0_pix_i;
	ppu_pixel_pkg::layer_pix_t layer1_pix_i;
	logic                      pix_vld_o;
	logic                      pix_rdy_i;
	ppu_pixel_pkg::lcd_pixel_t pix_o;
	logic                      running_o;
	ppu_pixel_pkg::coord_t     beam_x_o;
	ppu_pixel_pkg::coord_t     beam_y_o;
	logic                      hsync_o;
	logic                      vsync_o;

	// Stimulus table, one entry per pixel pair
	string       t_name [N_TESTS];
	logic [15:0] t_l0 [N_TESTS];
	logic [15:0] t_l1 [N_TESTS];
	logic [15:0] t_exp [N_TESTS];
	logic [14:0] pal_colour [8];

	logic [15:0] exp_q [$];
	string       name_q [$];
	integer      seed = 32'ha33c;
	logic [31:0] rnd;
	int          acc_cnt;
	int          out_cnt;
	logic        hs_prev;
	logic        exp_hsync;
	logic        exp_vsync;
	logic        lat_check;
	logic        rand_rdy;
	logic        rdy_sel;
	logic        halt_armed;

	ppu_core uut (
		.clk_ppu      (clk_ppu),
		.rst_n_ppu    (rst_n_ppu),
		.reg_wr_i     (reg_wr_i),
		.run_i        (run_i),
		.halt_i       (halt_i),
		.layer_vld_i  (layer_vld_i),
		.layer_rdy_o  (layer_rdy_o),
		.layer0_pix_i (layer0_pix_i),
		.layer1_pix_i (layer1_pix_i),
		.pix_vld_o    (pix_vld_o),
		.pix_rdy_i    (pix_rdy_i),
		.pix_o        (pix_o),
		.running_o    (running_o),
		.beam_x_o     (beam_x_o),
		.beam_y_o     (beam_y_o),
		.hsync_o      (hsync_o),
		.vsync_o      (vsync_o)
	);

	initial clk_ppu = 1'b0;
	always #2 clk_ppu = ~clk_ppu;

	// ----------------------------------------
	// Reference model and helpers

	// Layer 1 over layer 0 over backdrop, only layer 0 is paletted here
	function automatic logic [15:0] ref_lcd(input logic [15:0] l0, input logic [15:0] l1);
		logic [14:0] c;
		logic [15:0] red;
		logic [15:0] green;
		logic [15:0] blue;
		if (l1[15])
			c = l1[14:0];
		else if (l0[15])
			c = pal_colour[l0[2:0]];
		else
			c = DEF_BG;
		red   = 16'(c[14:10]);
		green = 16'(c[9:5]);
		blue  = 16'(c[4:0]);
		// Green doubles to six bits, red moves up past it
		return (red << 11) | (green << 6) | blue;
	endfunction

	task automatic build_table();
		string kind;
		logic  a0;
		logic  a1;
		for (int i = 0; i < N_TESTS; i++) begin
			a0 = (i % 4 == 1) || (i % 4 == 3);
			a1 = (i % 4 >= 2);
			case (i % 4)
				0: kind = "backdrop";
				1: kind = "l0_palette";
				2: kind = "l1_direct";
				default: kind = "l1_over_l0";
			endcase
			t_name[i] = $sformatf("%s_%0d", kind, i);
			// Index bits above 2 stay zero, only eight entries are loaded
			t_l0[i]  = {a0, 7'(i * 3), 8'(i % 8)};
			t_l1[i]  = {a1, 15'(i * 'h0a53 + 'h0111)};
			t_exp[i] = ref_lcd(t_l0[i], t_l1[i]);
		end
	endtask

	task automatic report_fail(input string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1);
	endtask

	task automatic write_reg(input logic [`PPU_W_REG_ADDR-1:0] addr,
			input logic [`PPU_W_REG_DATA-1:0] data);
		reg_wr_i.wen   = 1'b1;
		reg_wr_i.addr  = addr;
		reg_wr_i.wdata = data;
		@(posedge clk_ppu);
		#1;
		reg_wr_i.wen = 1'b0;
	endtask

	task automatic pulse_run();
		run_i = 1'b1;
		@(posedge clk_ppu);
		#1;
		run_i = 1'b0;
	endtask

	// Hold the pair until both layers are taken
	task automatic send_entry(input int idx);
		layer_vld_i  = 2'b11;
		layer0_pix_i = t_l0[idx];
		layer1_pix_i = t_l1[idx];
		do
			@(posedge clk_ppu);
		while (layer_rdy_o != 2'b11);
		exp_q.push_back(t_exp[idx]);
		name_q.push_back(t_name[idx]);
		#1;
		layer_vld_i = 2'b00;
	endtask

	task automatic wait_drain();
		do
			@(posedge clk_ppu);
		while (exp_q.size() != 0 || pix_vld_o);
		#1;
	endtask

	// Random stall pattern on the output port
	always @(posedge clk_ppu) begin
		rdy_sel = rand_rdy;
		#1;
		rnd = $random(seed);
		pix_rdy_i = rdy_sel ? rnd[0] : 1'b1;
	end

	// ----------------------------------------
	// Monitor, sampled on the rising edge

	always @(posedge clk_ppu) begin : monitor
		logic        hs;
		logic [15:0] exp_pix;
		string       exp_name;
		if (rst_n_ppu) begin
			if (lat_check && hs_prev)
				assert (pix_vld_o)
					else report_fail("no output pixel one cycle after a layer handshake");
			assert (beam_x_o == acc_cnt % 4) else report_fail($sformatf(
				"mismatch raster_x: expected %0d actual %0d", acc_cnt % 4, beam_x_o));
			assert (beam_y_o == (acc_cnt / 4) % 2) else report_fail($sformatf(
				"mismatch raster_y: expected %0d actual %0d", (acc_cnt / 4) % 2, beam_y_o));
			assert (hsync_o == exp_hsync) else report_fail($sformatf(
				"mismatch raster_hsync: expected %0b actual %0b", exp_hsync, hsync_o));
			assert (vsync_o == exp_vsync) else report_fail($sformatf(
				"mismatch raster_vsync: expected %0b actual %0b", exp_vsync, vsync_o));
			if (halt_armed && vsync_o)
				assert (!running_o) else report_fail("running stayed high at frame start");
			if (pix_vld_o && pix_rdy_i) begin
				assert (exp_q.size() != 0)
					else report_fail("output pixel appeared with nothing expected");
				exp_pix  = exp_q.pop_front();
				exp_name = name_q.pop_front();
				assert (pix_o == exp_pix) else report_fail($sformatf(
					"mismatch %s: expected %h actual %h", exp_name, exp_pix, pix_o));
				out_cnt++;
			end
			hs        = layer_vld_i[0] && layer_rdy_o[0];
			exp_hsync = hs && (acc_cnt % 4 == 3);
			exp_vsync = hs && (acc_cnt % 8 == 7);
			if (hs)
				acc_cnt++;
			hs_prev = hs;
		end
	end

	initial begin
		repeat (N_TESTS * 20 + 200) @(posedge clk_ppu);
		report_fail("output stalled, watchdog expired before all pixels came out");
	end

	// ----------------------------------------
	// Test sequence

	initial begin
		rst_n_ppu    = 1'b0;
		reg_wr_i     = '0;
		run_i        = 1'b0;
		halt_i       = 1'b0;
		layer_vld_i  = 2'b00;
		layer0_pix_i = '0;
		layer1_pix_i = '0;
		pix_rdy_i    = 1'b1;
		acc_cnt      = 0;
		out_cnt      = 0;
		hs_prev      = 1'b0;
		exp_hsync    = 1'b0;
		exp_vsync    = 1'b0;
		lat_check    = 1'b0;
		rand_rdy     = 1'b0;
		halt_armed   = 1'b0;
		for (int i = 0; i < 8; i++)
			pal_colour[i] = 15'(i * 'h0c63 + 'h1084);
		build_table();
		repeat (10) @(posedge clk_ppu);
		#1;
		rst_n_ppu = 1'b1;
		@(posedge clk_ppu);
		#1;

		// 4x2 display, layer 0 paletted
		write_reg(`PPU_REG_DISPSIZE, 32'h0001_0003);
		write_reg(`PPU_REG_DEFAULT_BG, {17'd0, DEF_BG});
		write_reg(`PPU_REG_LAYER_CFG, 32'd1);
		for (int i = 0; i < 8; i++)
			write_reg({1'b1, 8'(i)}, {17'd0, pal_colour[i]});

		// Layers offer data but nothing moves before run
		layer_vld_i  = 2'b11;
		layer0_pix_i = t_l0[0];
		layer1_pix_i = t_l1[0];
		repeat (5) begin
			@(posedge clk_ppu);
			assert (!running_o && !pix_vld_o && layer_rdy_o == 2'b00)
				else report_fail("pixel path moved before the run pulse");
		end
		#1;
		pulse_run();

		// Full rate frame
		lat_check = 1'b1;
		for (int i = 0; i < FRAME; i++)
			send_entry(i);
		@(posedge clk_ppu);
		#1;
		lat_check = 1'b0;

		// Back-pressure frame
		rand_rdy = 1'b1;
		for (int i = FRAME; i < 2 * FRAME; i++)
			send_entry(i);
		rand_rdy = 1'b0;
		wait_drain();

		// Halt at the next frame start
		write_reg(`PPU_REG_CSR, 32'd2);
		halt_armed = 1'b1;
		for (int i = 2 * FRAME; i < 3 * FRAME; i++)
			send_entry(i);
		layer_vld_i  = 2'b11;
		layer0_pix_i = t_l0[N_TESTS-1];
		layer1_pix_i = t_l1[N_TESTS-1];
		repeat (10) begin
			@(posedge clk_ppu);
			assert (!running_o && layer_rdy_o == 2'b00)
				else report_fail("pixel accepted after halt at frame start");
		end
		#1;
		assert (acc_cnt == 3 * FRAME) else report_fail($sformatf(
			"mismatch halt_count: expected %0d actual %0d", 3 * FRAME, acc_cnt));
		halt_armed = 1'b0;
		write_reg(`PPU_REG_CSR, 32'd0);
		pulse_run();
		send_entry(N_TESTS - 1);
		wait_drain();

		if (exp_q.size() == 0 && out_cnt == N_TESTS) begin
			$display("TB PASSED");
			$finish;
		end else begin
			report_fail($sformatf("mismatch output_count: expected %0d actual %0d",
				N_TESTS, out_cnt));
		end
	end

endmodule

// File: hdl/ppu_blender.sv
`timescale 1ns/1ps

module ppu_blender (
	input  logic [1:0]                layer_vld_i,
	output logic [1:0]                layer_rdy_o,
	input  ppu_pixel_pkg::layer_pix_t layer0_i,
	input  ppu_pixel_pkg::layer_pix_t layer1_i,
	input  ppu_pixel_pkg::pixel_t     default_bg_i,
	input  logic [1:0]                layer_paletted_i,
	output logic                      out_vld_o,
	input  logic                      out_rdy_i,
	output ppu_pixel_pkg::blend_pix_t out_o
);

	logic xfer;

	// ----------------------------------------
	// Handshake

	// Layers move in lockstep, one pixel from each per beam position
	assign out_vld_o   = &layer_vld_i;
	assign xfer        = out_vld_o && out_rdy_i;
	assign layer_rdy_o = {2{xfer}};

	// ----------------------------------------
	// Priority blend

	always_comb begin
		if (layer1_i.alpha) begin
			out_o.paletted = layer_paletted_i[1];
			out_o.pixdata  = layer1_i.pixdata;
		end else if (layer0_i.alpha) begin
			out_o.paletted = layer_paletted_i[0];
			out_o.pixdata  = layer0_i.pixdata;
		end else begin
			// Nothing opaque, show backdrop colour directly
			out_o.paletted = 1'b0;
			out_o.pixdata  = default_bg_i;
		end
	end

endmodule

// File: hdl/ppu_cfg_pkg.sv
`include "ppu_defines.svh"

package ppu_cfg_pkg;

	// Live configuration seen by the pixel path
	typedef struct packed {
		ppu_pixel_pkg::coord_t last_x;
		ppu_pixel_pkg::coord_t last_y;
		ppu_pixel_pkg::pixel_t default_bg;
		logic [1:0]            layer_paletted;
		logic                  halt_hsync;
		logic                  halt_vsync;
	} ppu_cfg_t;

	// Plain register write strobe
	typedef struct packed {
		logic                         wen;
		logic [`PPU_W_REG_ADDR-1:0]   addr;
		logic [`PPU_W_REG_DATA-1:0]   wdata;
	} reg_wr_t;

	// Palette RAM write port
	typedef struct packed {
		logic                    wen;
		ppu_pixel_pkg::pal_idx_t idx;
		ppu_pixel_pkg::pixel_t   colour;
	} pal_wr_t;

	typedef enum logic {RUN_IDLE, RUN_ACTIVE} run_state_e;

endpackage

// File: hdl/ppu_core.sv
`timescale 1ns/1ps

module ppu_core (
	input  logic                      clk_ppu,
	input  logic                      rst_n_ppu,
	input  ppu_cfg_pkg::reg_wr_t      reg_wr_i,
	input  logic                      run_i,
	input  logic                      halt_i,
	input  logic [1:0]                layer_vld_i,
	output logic [1:0]                layer_rdy_o,
	input  ppu_pixel_pkg::layer_pix_t layer0_pix_i,
	input  ppu_pixel_pkg::layer_pix_t layer1_pix_i,
	output logic                      pix_vld_o,
	input  logic                      pix_rdy_i,
	output ppu_pixel_pkg::lcd_pixel_t pix_o,
	output logic                      running_o,
	output ppu_pixel_pkg::coord_t     beam_x_o,
	output ppu_pixel_pkg::coord_t     beam_y_o,
	output logic                      hsync_o,
	output logic                      vsync_o
);

	ppu_cfg_pkg::ppu_cfg_t     cfg;
	ppu_cfg_pkg::pal_wr_t      pal_wr;
	ppu_pixel_pkg::blend_pix_t blend_pix;
	logic                      running;
	logic                      hsync;
	logic                      vsync;
	logic                      blend_vld;
	logic                      blend_rdy;
	logic                      pmap_in_vld;
	logic                      pmap_in_rdy;

	// ----------------------------------------
	// Control and raster

	ppu_ctrl_regs u_ctrl_regs (
		.clk_ppu   (clk_ppu),
		.rst_n_ppu (rst_n_ppu),
		.reg_wr_i  (reg_wr_i),
		.run_i     (run_i),
		.halt_i    (halt_i),
		.hsync_i   (hsync),
		.vsync_i   (vsync),
		.cfg_o     (cfg),
		.pal_wr_o  (pal_wr),
		.running_o (running)
	);

	ppu_raster_counter u_raster_counter (
		.clk_ppu   (clk_ppu),
		.rst_n_ppu (rst_n_ppu),
		.advance_i (blend_vld && blend_rdy),
		.last_x_i  (cfg.last_x),
		.last_y_i  (cfg.last_y),
		.beam_x_o  (beam_x_o),
		.beam_y_o  (beam_y_o),
		.hsync_o   (hsync),
		.vsync_o   (vsync)
	);

	// ----------------------------------------
	// Pixel path

	ppu_blender u_blender (
		.layer_vld_i      (layer_vld_i),
		.layer_rdy_o      (layer_rdy_o),
		.layer0_i         (layer0_pix_i),
		.layer1_i         (layer1_pix_i),
		.default_bg_i     (cfg.default_bg),
		.layer_paletted_i (cfg.layer_paletted),
		.out_vld_o        (blend_vld),
		.out_rdy_i        (blend_rdy),
		.out_o            (blend_pix)
	);

	// Halted PPU neither offers nor takes pixels
	assign pmap_in_vld = blend_vld && running;
	assign blend_rdy   = pmap_in_rdy && running;

	ppu_palette_mapper u_palette_mapper (
		.clk_ppu   (clk_ppu),
		.rst_n_ppu (rst_n_ppu),
		.in_vld_i  (pmap_in_vld),
		.in_rdy_o  (pmap_in_rdy),
		.in_i      (blend_pix),
		.pal_wr_i  (pal_wr),
		.out_vld_o (pix_vld_o),
		.out_rdy_i (pix_rdy_i),
		.out_o     (pix_o)
	);

	assign running_o = running;
	assign hsync_o   = hsync;
	assign vsync_o   = vsync;

endmodule

// File: hdl/ppu_ctrl_regs.sv
`timescale 1ns/1ps
`include "ppu_defines.svh"

module ppu_ctrl_regs (
	input  logic                  clk_ppu,
	input  logic                  rst_n_ppu,
	input  ppu_cfg_pkg::reg_wr_t  reg_wr_i,
	input  logic                  run_i,
	input  logic                  halt_i,
	input  logic                  hsync_i,
	input  logic                  vsync_i,
	output ppu_cfg_pkg::ppu_cfg_t cfg_o,
	output ppu_cfg_pkg::pal_wr_t  pal_wr_o,
	output logic                  running_o
);

	ppu_cfg_pkg::ppu_cfg_t   cfg_q;
	ppu_cfg_pkg::run_state_e state_q;
	ppu_cfg_pkg::run_state_e state_d;
	logic                    pal_win;
	logic                    sync_stop;

	// ----------------------------------------
	// Register writes

	// Top address bit selects the palette window
	assign pal_win = reg_wr_i.addr[`PPU_W_REG_ADDR-1];

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu) begin
			cfg_q            <= '0;
			cfg_q.last_x     <= `PPU_RST_LAST_X;
			cfg_q.last_y     <= `PPU_RST_LAST_Y;
		end else if (reg_wr_i.wen && !pal_win) begin
			case (reg_wr_i.addr)
				`PPU_REG_CSR: begin
					cfg_q.halt_hsync <= reg_wr_i.wdata[0];
					cfg_q.halt_vsync <= reg_wr_i.wdata[1];
				end
				`PPU_REG_DISPSIZE: begin
					cfg_q.last_x <= reg_wr_i.wdata[9:0];
					cfg_q.last_y <= reg_wr_i.wdata[25:16];
				end
				`PPU_REG_DEFAULT_BG: cfg_q.default_bg     <= reg_wr_i.wdata[14:0];
				`PPU_REG_LAYER_CFG:  cfg_q.layer_paletted <= reg_wr_i.wdata[1:0];
				default: ;
			endcase
		end
	end

	assign cfg_o = cfg_q;

	// Palette writes go straight through to the mapper RAM
	always_comb begin
		pal_wr_o.wen    = reg_wr_i.wen && pal_win;
		pal_wr_o.idx    = reg_wr_i.addr[`PPU_W_PAL_IDX-1:0];
		pal_wr_o.colour = reg_wr_i.wdata[`PPU_W_PIXDATA-1:0];
	end

	// ----------------------------------------
	// Run control

	// Sync pulses are registered, so stopping on them is exact
	assign sync_stop = (cfg_q.halt_vsync && vsync_i) || (cfg_q.halt_hsync && hsync_i);
	assign running_o = (state_q == ppu_cfg_pkg::RUN_ACTIVE) && !sync_stop;

	always_comb begin
		state_d = state_q;
		if (halt_i)
			state_d = ppu_cfg_pkg::RUN_IDLE;
		else if (run_i)
			state_d = ppu_cfg_pkg::RUN_ACTIVE;
		else if (sync_stop)
			state_d = ppu_cfg_pkg::RUN_IDLE;
	end

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu)
			state_q <= ppu_cfg_pkg::RUN_IDLE;
		else
			state_q <= state_d;
	end

	// Software never issues both strobes in one cycle
	a_run_halt_excl: assert property (
		@(posedge clk_ppu) disable iff (!rst_n_ppu)
		!(run_i && halt_i)
	);

endmodule

// File: hdl/ppu_defines.svh
`ifndef PPU_DEFINES_SVH
`define PPU_DEFINES_SVH

// Datapath widths
`define PPU_W_PIXDATA      15
`define PPU_W_LCD_PIXDATA  16
`define PPU_W_COORD        10
`define PPU_W_PAL_IDX      8
`define PPU_W_REG_ADDR     9
`define PPU_W_REG_DATA     32

// Register map, palette window is any address with the top bit set
`define PPU_REG_CSR        9'd0
`define PPU_REG_DISPSIZE   9'd1
`define PPU_REG_DEFAULT_BG 9'd2
`define PPU_REG_LAYER_CFG  9'd3

// Display size out of reset, 8x4
`define PPU_RST_LAST_X     10'd7
`define PPU_RST_LAST_Y     10'd3

`endif

// File: hdl/ppu_palette_mapper.sv
`timescale 1ns/1ps
`include "ppu_defines.svh"

module ppu_palette_mapper (
	input  logic                      clk_ppu,
	input  logic                      rst_n_ppu,
	input  logic                      in_vld_i,
	output logic                      in_rdy_o,
	input  ppu_pixel_pkg::blend_pix_t in_i,
	input  ppu_cfg_pkg::pal_wr_t      pal_wr_i,
	output logic                      out_vld_o,
	input  logic                      out_rdy_i,
	output ppu_pixel_pkg::lcd_pixel_t out_o
);

	localparam int PAL_DEPTH = 1 << `PPU_W_PAL_IDX;

	ppu_pixel_pkg::pixel_t   pal_ram [PAL_DEPTH];
	ppu_pixel_pkg::pixel_t   out_pix_q;
	ppu_pixel_pkg::pal_idx_t rd_idx;
	logic                    out_vld_q;
	logic                    accept;

	// ----------------------------------------
	// Palette RAM

	always_ff @(posedge clk_ppu) begin
		if (pal_wr_i.wen)
			pal_ram[pal_wr_i.idx] <= pal_wr_i.colour;
	end

	assign rd_idx = in_i.pixdata[`PPU_W_PAL_IDX-1:0];

	// ----------------------------------------
	// Output stage

	// Take a new pixel when empty or when the current one leaves
	assign in_rdy_o = !out_vld_q || out_rdy_i;
	assign accept   = in_vld_i && in_rdy_o;

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu)
			out_vld_q <= 1'b0;
		else if (accept)
			out_vld_q <= 1'b1;
		else if (out_rdy_i)
			out_vld_q <= 1'b0;
	end

	always_ff @(posedge clk_ppu) begin
		if (accept)
			out_pix_q <= in_i.paletted ? pal_ram[rd_idx] : in_i.pixdata;
	end

	assign out_vld_o = out_vld_q;

	// RGB555 to RGB565, green gains a zero LSB
	assign out_o = {out_pix_q[14:5], 1'b0, out_pix_q[4:0]};

	// Stalled output holds both valid and data
	a_out_hold: assert property (
		@(posedge clk_ppu) disable iff (!rst_n_ppu)
		out_vld_o && !out_rdy_i |=> out_vld_o && $stable(out_o)
	);

endmodule

// File: hdl/ppu_pixel_pkg.sv
`include "ppu_defines.svh"

package ppu_pixel_pkg;

	// RGB555, red in the top field
	typedef logic [`PPU_W_PIXDATA-1:0] pixel_t;

	// RGB565 as sent to the panel
	typedef logic [`PPU_W_LCD_PIXDATA-1:0] lcd_pixel_t;

	typedef logic [`PPU_W_COORD-1:0] coord_t;

	typedef logic [`PPU_W_PAL_IDX-1:0] pal_idx_t;

	// Pixel from a layer source, alpha set means opaque
	typedef struct packed {
		logic   alpha;
		pixel_t pixdata;
	} layer_pix_t;

	// Blender output, paletted pixels carry an index in the low bits
	typedef struct packed {
		logic   paletted;
		pixel_t pixdata;
	} blend_pix_t;

endpackage

// File: hdl/ppu_raster_counter.sv
`timescale 1ns/1ps

module ppu_raster_counter (
	input  logic                  clk_ppu,
	input  logic                  rst_n_ppu,
	input  logic                  advance_i,
	input  ppu_pixel_pkg::coord_t last_x_i,
	input  ppu_pixel_pkg::coord_t last_y_i,
	output ppu_pixel_pkg::coord_t beam_x_o,
	output ppu_pixel_pkg::coord_t beam_y_o,
	output logic                  hsync_o,
	output logic                  vsync_o
);

	ppu_pixel_pkg::coord_t x_q;
	ppu_pixel_pkg::coord_t y_q;
	logic                  hsync_q;
	logic                  vsync_q;
	logic                  x_wrap;
	logic                  y_wrap;

	assign x_wrap = (x_q == last_x_i);
	assign y_wrap = (y_q == last_y_i);

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu) begin
			x_q     <= '0;
			y_q     <= '0;
			hsync_q <= 1'b0;
			vsync_q <= 1'b0;
		end else begin
			// Pulses mark the first pixel of a new row or frame
			hsync_q <= advance_i && x_wrap;
			vsync_q <= advance_i && x_wrap && y_wrap;
			if (advance_i) begin
				if (x_wrap) begin
					x_q <= '0;
					y_q <= y_wrap ? '0 : y_q + 1'b1;
				end else begin
					x_q <= x_q + 1'b1;
				end
			end
		end
	end

	assign beam_x_o = x_q;
	assign beam_y_o = y_q;
	assign hsync_o  = hsync_q;
	assign vsync_o  = vsync_q;

	// Beam never leaves the configured display area
	a_beam_in_range: assert property (
		@(posedge clk_ppu) disable iff (!rst_n_ppu)
		(beam_x_o <= last_x_i) && (beam_y_o <= last_y_i)
	);

endmodule

// File: ppu_core.f
+incdir+hdl
hdl/ppu_pixel_pkg.sv
hdl/ppu_cfg_pkg.sv
hdl/ppu_ctrl_regs.sv
hdl/ppu_raster_counter.sv
hdl/ppu_blender.sv
hdl/ppu_palette_mapper.sv
hdl/ppu_core.sv
bench/tb_ppu_core.sv
